/* hw/i2c_defines.svh */
//--------------------
// I2C master build-time constants
// slave address, bus widths and phase lengths in dri_clk cycles
//--------------------
`ifndef I2C_DEFINES_SVH
`define I2C_DEFINES_SVH

`define I2C_SLAVE_ADDR  7'b1010000          // 7-bit device address

`define I2C_ADDR_W      16                  // word address, up to two bytes
`define I2C_DATA_W      8                   // one data byte
`define I2C_CNT_W       7                   // quarter counter width

// phase lengths, four dri_clk cycles per SCL bit
`define I2C_LEN_ADDR_PH 40                  // start quarters + byte + ack
`define I2C_LEN_BYTE_PH 36                  // byte + ack slot
`define I2C_LEN_STOP_PH 17                  // stop sequence and bus free time

`endif

/* hw/i2c_bus_pkg.sv */
//--------------------
// I2C wire-level types
// bit engine phases and the drive of the two bus lines
//--------------------
package i2c_bus_pkg;

    // one phase is one fixed-length piece of a transaction
    typedef enum logic [2:0] {
        ph_idle         = 3'd0,             // bus released, counter held
        ph_start_byte   = 3'd1,             // start, then send a byte
        ph_restart_byte = 3'd2,             // release, repeated start, send a byte
        ph_tx_byte      = 3'd3,             // send a byte, slave acks
        ph_rx_byte      = 3'd4,             // receive a byte, send nack
        ph_stop         = 3'd5              // stop condition
    } i2c_phase_e;

    // line drive toward the pads
    typedef struct packed {
        logic scl;                          // clock line, push-pull
        logic sda_o;                        // data value when driven
        logic sda_oe;                       // 1 drives sda, 0 releases it
    } i2c_line_t;

endpackage

/* hw/i2c_txn_pkg.sv */
//--------------------
// I2C transaction types
// user request and sequencer states
//--------------------
`include "i2c_defines.svh"

package i2c_txn_pkg;

    // one request, sampled together with i2c_exec
    typedef struct packed {
        logic                   rh_wl;      // 1 read, 0 write
        logic                   bit_ctrl;   // 1 for 16-bit word address
        logic [`I2C_ADDR_W-1:0] addr;       // word address inside the device
        logic [`I2C_DATA_W-1:0] data_w;     // byte to write
    } i2c_req_t;

    // one-hot sequencer states
    typedef enum logic [7:0] {
        st_idle    = 8'b0000_0001,
        st_sladdr  = 8'b0000_0010,          // slave address, write
        st_addr16  = 8'b0000_0100,          // word address high byte
        st_addr8   = 8'b0000_1000,          // word address low byte
        st_data_wr = 8'b0001_0000,
        st_addr_rd = 8'b0010_0000,          // slave address, read
        st_data_rd = 8'b0100_0000,
        st_stop    = 8'b1000_0000
    } i2c_state_e;

endpackage

/* hw/i2c_bit_engine.sv */
//--------------------
// I2C bit engine
// quarter counter that shapes scl and sda for one phase
// and shifts the bits of one byte out or in
//--------------------
`timescale 1ns/1ps

`include "i2c_defines.svh"

module i2c_bit_engine (
    input  logic                    dri_clk,
    input  logic                    rst_n,
    input  i2c_bus_pkg::i2c_phase_e phase,          // constant for the whole phase
    input  logic [`I2C_DATA_W-1:0]  tx_byte,
    input  logic                    sda_i,
    output i2c_bus_pkg::i2c_line_t  line,
    output logic                    phase_done,
    output logic [`I2C_DATA_W-1:0]  rx_byte
);

    typedef logic [`I2C_CNT_W-1:0] cnt_t;

    cnt_t                    cnt;                   // quarter count inside the phase
    cnt_t                    cnt_nxt;
    cnt_t                    cnt_last;              // final count of this phase
    cnt_t                    bcnt;                  // count from the first data bit
    logic                    has_start;             // phase opens with a start
    logic                    in_byte;
    logic [`I2C_CNT_W-3:0]   bit_idx;               // 0..7 data, 8 ack slot
    logic [1:0]              quarter;
    logic                    ack_slot;
    logic                    scl_bit;
    logic                    shift_en;
    logic [`I2C_DATA_W-1:0]  rx_sh;
    i2c_bus_pkg::i2c_line_t  line_nxt;

    //--------------------
    // quarter counter
    //--------------------
    always_comb begin
        unique case (phase)
            i2c_bus_pkg::ph_start_byte,
            i2c_bus_pkg::ph_restart_byte: cnt_last = cnt_t'(`I2C_LEN_ADDR_PH - 1);
            i2c_bus_pkg::ph_tx_byte,
            i2c_bus_pkg::ph_rx_byte:      cnt_last = cnt_t'(`I2C_LEN_BYTE_PH - 1);
            i2c_bus_pkg::ph_stop:         cnt_last = cnt_t'(`I2C_LEN_STOP_PH - 1);
            default:                      cnt_last = '0;
        endcase
    end

    always_comb begin
        if ((phase == i2c_bus_pkg::ph_idle) || (cnt == cnt_last))
            cnt_nxt = '0;                           // wrap at the phase length
        else
            cnt_nxt = cnt + 1'b1;
    end

    //--------------------
    // bit timing
    //--------------------
    always_comb begin
        has_start = (phase == i2c_bus_pkg::ph_start_byte) ||
                    (phase == i2c_bus_pkg::ph_restart_byte);
        in_byte   = !has_start || (cnt >= cnt_t'(4));
        bcnt      = has_start ? cnt - cnt_t'(4) : cnt;
        bit_idx   = bcnt[`I2C_CNT_W-1:2];
        quarter   = bcnt[1:0];
        ack_slot  = (bit_idx == 5'd8);
        scl_bit   = (quarter == 2'd1) || (quarter == 2'd2);     // high for two quarters
        shift_en  = (phase == i2c_bus_pkg::ph_rx_byte) && !ack_slot &&
                    (quarter == 2'd1);                          // edge that raises scl
    end

    // line value for the next cycle, sda only moves in quarter 0
    always_comb begin
        line_nxt = '{scl: 1'b1, sda_o: 1'b1, sda_oe: 1'b1};
        unique case (phase)
            i2c_bus_pkg::ph_idle: ;                 // released bus
            i2c_bus_pkg::ph_stop: begin
                line_nxt.scl   = (cnt != '0);
                line_nxt.sda_o = (cnt >= cnt_t'(3));    // sda rises with scl high
            end
            default: begin
                if (!in_byte) begin
                    unique case (cnt[1:0])
                        2'd0: begin
                            line_nxt.scl   = (phase == i2c_bus_pkg::ph_start_byte);
                            line_nxt.sda_o = 1'b1;      // release before restart
                        end
                        2'd1: begin
                            line_nxt.scl   = 1'b1;
                            line_nxt.sda_o = (phase == i2c_bus_pkg::ph_restart_byte);
                        end
                        2'd2: begin
                            line_nxt.scl   = 1'b1;
                            line_nxt.sda_o = 1'b0;      // start held
                        end
                        default: begin
                            line_nxt.scl   = 1'b0;
                            line_nxt.sda_o = 1'b0;
                        end
                    endcase
                end else begin
                    line_nxt.scl = scl_bit;
                    if (ack_slot) begin
                        // slave acks a write, master nacks a read
                        line_nxt.sda_oe = (phase == i2c_bus_pkg::ph_rx_byte);
                    end else if (phase == i2c_bus_pkg::ph_rx_byte) begin
                        line_nxt.sda_oe = 1'b0;         // slave drives data
                    end else begin
                        line_nxt.sda_o = tx_byte[~bit_idx[2:0]];    // msb first
                    end
                end
            end
        endcase
    end

    //--------------------
    // registers
    //--------------------
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt        <= '0;
            phase_done <= 1'b0;
            line       <= '{scl: 1'b1, sda_o: 1'b1, sda_oe: 1'b1};
        end else begin
            cnt        <= cnt_nxt;
            phase_done <= (phase != i2c_bus_pkg::ph_idle) && (cnt_nxt == cnt_last);
            line       <= line_nxt;
        end
    end

    always_ff @(posedge dri_clk) begin
        if (shift_en)
            rx_sh <= {rx_sh[`I2C_DATA_W-2:0], sda_i};
    end

    assign rx_byte = rx_sh;                         // valid with phase_done

endmodule

/* hw/i2c_txn_seq.sv */
//--------------------
// I2C transaction sequencer
// walks the states of one write or random read and picks each phase
//--------------------
`timescale 1ns/1ps

`include "i2c_defines.svh"

module i2c_txn_seq (
    input  logic                    dri_clk,
    input  logic                    rst_n,
    input  logic                    i2c_exec,
    input  i2c_txn_pkg::i2c_req_t   i2c_req,
    input  logic                    phase_done,     // last cycle of a phase
    input  logic [`I2C_DATA_W-1:0]  rx_byte,
    output i2c_bus_pkg::i2c_phase_e phase,
    output logic [`I2C_DATA_W-1:0]  tx_byte,
    output logic [`I2C_DATA_W-1:0]  i2c_data_r,
    output logic                    i2c_done
);

    i2c_txn_pkg::i2c_state_e st;
    i2c_txn_pkg::i2c_state_e st_nxt;
    i2c_txn_pkg::i2c_req_t   req_q;             // request held for the transaction

    //--------------------
    // state transitions
    //--------------------
    always_comb begin
        st_nxt = st;
        unique case (st)
            i2c_txn_pkg::st_idle: begin
                if (i2c_exec)
                    st_nxt = i2c_txn_pkg::st_sladdr;
            end
            i2c_txn_pkg::st_sladdr: begin
                if (phase_done)
                    st_nxt = req_q.bit_ctrl ? i2c_txn_pkg::st_addr16 : i2c_txn_pkg::st_addr8;
            end
            i2c_txn_pkg::st_addr16: begin
                if (phase_done)
                    st_nxt = i2c_txn_pkg::st_addr8;
            end
            i2c_txn_pkg::st_addr8: begin
                if (phase_done)
                    st_nxt = req_q.rh_wl ? i2c_txn_pkg::st_addr_rd : i2c_txn_pkg::st_data_wr;
            end
            i2c_txn_pkg::st_data_wr: begin
                if (phase_done)
                    st_nxt = i2c_txn_pkg::st_stop;
            end
            i2c_txn_pkg::st_addr_rd: begin
                if (phase_done)
                    st_nxt = i2c_txn_pkg::st_data_rd;
            end
            i2c_txn_pkg::st_data_rd: begin
                if (phase_done)
                    st_nxt = i2c_txn_pkg::st_stop;
            end
            i2c_txn_pkg::st_stop: begin
                if (phase_done)
                    st_nxt = i2c_txn_pkg::st_idle;
            end
            default: st_nxt = i2c_txn_pkg::st_idle;
        endcase
    end

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            st         <= i2c_txn_pkg::st_idle;
            i2c_done   <= 1'b0;
            i2c_data_r <= '0;
        end else begin
            st       <= st_nxt;
            i2c_done <= (st == i2c_txn_pkg::st_stop) && phase_done;   // one-cycle pulse
            if ((st == i2c_txn_pkg::st_data_rd) && phase_done)
                i2c_data_r <= rx_byte;                              // reads only
        end
    end

    // busy strobes are dropped here
    always_ff @(posedge dri_clk) begin
        if ((st == i2c_txn_pkg::st_idle) && i2c_exec)
            req_q <= i2c_req;
    end

    //--------------------
    // phase and byte per state
    //--------------------
    always_comb begin
        phase   = i2c_bus_pkg::ph_idle;
        tx_byte = '0;
        unique case (st)
            i2c_txn_pkg::st_sladdr: begin
                phase   = i2c_bus_pkg::ph_start_byte;
                tx_byte = {`I2C_SLAVE_ADDR, 1'b0};              // write
            end
            i2c_txn_pkg::st_addr16: begin
                phase   = i2c_bus_pkg::ph_tx_byte;
                tx_byte = req_q.addr[`I2C_ADDR_W-1:`I2C_DATA_W];
            end
            i2c_txn_pkg::st_addr8: begin
                phase   = i2c_bus_pkg::ph_tx_byte;
                tx_byte = req_q.addr[`I2C_DATA_W-1:0];
            end
            i2c_txn_pkg::st_data_wr: begin
                phase   = i2c_bus_pkg::ph_tx_byte;
                tx_byte = req_q.data_w;
            end
            i2c_txn_pkg::st_addr_rd: begin
                phase   = i2c_bus_pkg::ph_restart_byte;
                tx_byte = {`I2C_SLAVE_ADDR, 1'b1};              // read
            end
            i2c_txn_pkg::st_data_rd: phase = i2c_bus_pkg::ph_rx_byte;
            i2c_txn_pkg::st_stop:    phase = i2c_bus_pkg::ph_stop;
            default: ;
        endcase
    end

endmodule

/* hw/i2c_master.sv */
//--------------------
// I2C bus master, single slave
// transaction sequencer feeding a quarter-clock bit engine
//--------------------
`timescale 1ns/1ps

`include "i2c_defines.svh"

module i2c_master (
    input  logic                   dri_clk,     // four times the SCL rate
    input  logic                   rst_n,
    input  logic                   i2c_exec,    // one-cycle start strobe
    input  i2c_txn_pkg::i2c_req_t  i2c_req,
    output logic [`I2C_DATA_W-1:0] i2c_data_r,
    output logic                   i2c_done,
    output logic                   scl,
    output logic                   sda_o,
    output logic                   sda_oe,
    input  logic                   sda_i        // sampled pad value
);

    i2c_bus_pkg::i2c_phase_e  phase;
    logic [`I2C_DATA_W-1:0]   tx_byte;
    logic [`I2C_DATA_W-1:0]   rx_byte;
    logic                     phase_done;
    i2c_bus_pkg::i2c_line_t   line;

    i2c_txn_seq u_seq (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_exec   (i2c_exec),
        .i2c_req    (i2c_req),
        .phase_done (phase_done),
        .rx_byte    (rx_byte),
        .phase      (phase),
        .tx_byte    (tx_byte),
        .i2c_data_r (i2c_data_r),
        .i2c_done   (i2c_done)
    );

    i2c_bit_engine u_eng (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .phase      (phase),
        .tx_byte    (tx_byte),
        .sda_i      (sda_i),
        .line       (line),
        .phase_done (phase_done),
        .rx_byte    (rx_byte)
    );

    // pads, tri-state buffer lives in the board top
    assign scl    = line.scl;
    assign sda_o  = line.sda_o;
    assign sda_oe = line.sda_oe;

endmodule

/* tests/i2c_master_chk.sv */
//--------------------
// I2C master bus checks
// line, phase and done rules as concurrent assertions
//--------------------
`timescale 1ns/1ps

module i2c_master_chk (
    input logic                    dri_clk,
    input logic                    rst_n,
    input i2c_bus_pkg::i2c_phase_e phase,
    input i2c_bus_pkg::i2c_line_t  line,
    input logic                    phase_done,
    input logic                    done
);

    // data bits only change with scl low
    a_sda_stable: assert property (@(posedge dri_clk) disable iff (!rst_n)
        ((phase == i2c_bus_pkg::ph_tx_byte) || (phase == i2c_bus_pkg::ph_rx_byte)) &&
        line.scl && $past(line.scl) |-> $stable(line.sda_o))
        else $error("sda_o changed while scl was high");

    a_idle_no_done: assert property (@(posedge dri_clk) disable iff (!rst_n)
        (phase == i2c_bus_pkg::ph_idle) |-> !phase_done)
        else $error("phase_done high in idle");

    a_idle_scl: assert property (@(posedge dri_clk) disable iff (!rst_n)
        (phase == i2c_bus_pkg::ph_idle) |-> line.scl)
        else $error("scl low in idle");

    // done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge dri_clk) disable iff (!rst_n)
        done |=> !done)
        else $error("i2c_done high for two cycles");

endmodule

/* tests/tb_i2c_master.sv */
//--------------------
// I2C master testbench
// vector driven transactions against a simple slave model
//--------------------
`timescale 1ns/1ps

`include "i2c_defines.svh"

module tb_i2c_master;

    logic                   dri_clk;
    logic                   rst_n;
    logic                   i2c_exec;
    i2c_txn_pkg::i2c_req_t  i2c_req;
    logic [`I2C_DATA_W-1:0] i2c_data_r;
    logic                   i2c_done;
    logic                   scl;
    logic                   sda_o;
    logic                   sda_oe;
    logic                   sda_i;
    logic                   sda_bus;

    logic [39:0]            vec_mem [0:31];
    logic [7:0]             slv_mem [0:255];
    logic [7:0]             got_q [$];          // bytes the slave received
    logic [7:0]             sh;
    logic [7:0]             rd_sh;
    logic [7:0]             ptr;
    logic                   slv_low;            // slave pulls sda low
    logic                   prev_scl;
    logic                   prev_sda;
    logic                   reading;
    logic                   rd_first;
    logic                   got_nack;
    logic                   cur_16;
    logic [15:0]            lfsr;
    logic [7:0]             last_rd;
    int                     bit_cnt;
    int                     byte_k;
    int                     n_start;
    int                     n_stop;
    int                     n_done;
    int                     nvec;
    int                     limit;
    int                     cycles;
    int                     err_byte;
    int                     err_line;
    int                     err_lat;

    i2c_master u_i2c_master (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_exec   (i2c_exec),
        .i2c_req    (i2c_req),
        .i2c_data_r (i2c_data_r),
        .i2c_done   (i2c_done),
        .scl        (scl),
        .sda_o      (sda_o),
        .sda_oe     (sda_oe),
        .sda_i      (sda_i)
    );

    bind i2c_master i2c_master_chk u_chk (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .phase      (phase),
        .line       (line),
        .phase_done (phase_done),
        .done       (i2c_done)
    );

    // open-drain wired and with pull-up
    assign sda_bus = (sda_oe ? sda_o : 1'b1) & ~slv_low;
    assign sda_i   = sda_bus;

    initial begin
        dri_clk = 1'b0;
        forever #10 dri_clk = ~dri_clk;
    end

    //--------------------
    // compare tasks
    //--------------------
    task automatic check_byte(input logic [`I2C_DATA_W-1:0] got,
                              input logic [`I2C_DATA_W-1:0] exp, input string what);
        if (got !== exp) begin
            err_byte++;
            $display("error %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_line(input i2c_bus_pkg::i2c_line_t got,
                              input i2c_bus_pkg::i2c_line_t exp);
        if (got !== exp) begin
            err_line++;
            $display("error %0t: bus lines got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        if (got != exp) begin
            err_lat++;
            $display("error %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    //--------------------
    // slave model
    //--------------------
    always @(negedge dri_clk) begin
        logic sda_now;
        sda_now = sda_bus;
        if (!rst_n) begin
            slv_low = 1'b0;
            bit_cnt = 0;
            reading = 1'b0;
            rd_first = 1'b0;
        end else if (scl && prev_scl && prev_sda && !sda_now) begin
            n_start++;                                  // start or repeated start
            bit_cnt = 0;
            byte_k  = 0;
            reading = 1'b0;
            slv_low = 1'b0;
        end else if (scl && prev_scl && !prev_sda && sda_now) begin
            n_stop++;
            bit_cnt = 0;
            reading = 1'b0;
            slv_low = 1'b0;
        end else if (scl && !prev_scl) begin
            if ((bit_cnt < 8) && !reading)
                sh = {sh[6:0], sda_now};
            if ((bit_cnt == 8) && reading)
                got_nack = sda_now;                     // master ack bit
            bit_cnt++;
        end else if (!scl && prev_scl) begin
            if ((bit_cnt == 8) && !reading) begin
                got_q.push_back(sh);
                if (byte_k == 0) begin
                    if (sh[0]) begin
                        reading  = 1'b1;
                        rd_first = 1'b1;
                        rd_sh    = slv_mem[ptr];
                    end
                end else if (byte_k <= (cur_16 ? 2 : 1)) begin
                    ptr = sh;                           // low byte comes last
                end else begin
                    slv_mem[ptr] = sh;
                end
                byte_k++;
                slv_low = 1'b1;                         // ack
            end else if (bit_cnt == 9) begin
                bit_cnt  = 0;
                slv_low  = rd_first & ~rd_sh[7];
                rd_first = 1'b0;
            end else if (reading) begin
                slv_low = (bit_cnt < 8) ? ~rd_sh[7-bit_cnt] : 1'b0;
            end
        end
        prev_scl = scl;
        prev_sda = sda_now;
    end

    always @(negedge dri_clk) begin
        if (rst_n && i2c_done)
            n_done++;
    end

    //--------------------
    // one transaction
    //--------------------
    task automatic run_vector(input logic [39:0] v);
        i2c_txn_pkg::i2c_req_t req;
        logic [7:0]            exp_q [$];
        logic [3:0]            gap;
        int                    lat;
        int                    exp_lat;
        req.rh_wl    = v[36];
        req.bit_ctrl = v[32];
        req.addr     = v[31:16];
        req.data_w   = v[15:8];
        for (int i = 0; i < 4; i++) begin
            lfsr = lfsr_step(lfsr);
            gap  = {gap[2:0], lfsr[0]};
        end
        repeat (gap) @(negedge dri_clk);
        cur_16   = req.bit_ctrl;
        got_nack = 1'b0;
        n_start  = 0;
        n_stop   = 0;
        got_q.delete();
        i2c_req  = req;
        i2c_exec = 1'b1;
        @(negedge dri_clk);
        i2c_exec = 1'b0;
        lat = 0;
        while (!i2c_done) begin
            @(negedge dri_clk);
            lat++;
            i2c_exec = (lat == 60);                     // strobe while busy
            if (lat == 60)
                i2c_req = i2c_txn_pkg::i2c_req_t'(~req);    // other request, ignored
        end
        i2c_exec = 1'b0;
        exp_lat = `I2C_LEN_ADDR_PH + `I2C_LEN_BYTE_PH * (req.bit_ctrl ? 3 : 2)
                + `I2C_LEN_STOP_PH + (req.rh_wl ? `I2C_LEN_ADDR_PH : 0);
        check_latency(lat, exp_lat, "latency");
        check_latency(n_start, req.rh_wl ? 2 : 1, "start count");
        check_latency(n_stop, 1, "stop count");
        exp_q.push_back({`I2C_SLAVE_ADDR, 1'b0});
        if (req.bit_ctrl)
            exp_q.push_back(req.addr[15:8]);
        exp_q.push_back(req.addr[7:0]);
        exp_q.push_back(req.rh_wl ? {`I2C_SLAVE_ADDR, 1'b1} : req.data_w);
        check_latency(got_q.size(), exp_q.size(), "byte count");
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
            check_byte(got_q[i], exp_q[i], "bus byte");
        if (req.rh_wl) begin
            check_byte(i2c_data_r, v[7:0], "read data");
            check_latency(int'(got_nack), 1, "nack after read");
            last_rd = v[7:0];
        end else begin
            check_byte(slv_mem[req.addr[7:0]], req.data_w, "slave memory");
            check_byte(i2c_data_r, last_rd, "held read data");
        end
    endtask

    //--------------------
    // main sequence
    //--------------------
    initial begin
        i2c_bus_pkg::i2c_line_t idle_line;
        rst_n    = 1'b0;
        i2c_exec = 1'b0;
        i2c_req  = '0;
        slv_low  = 1'b0;
        prev_scl = 1'b1;
        prev_sda = 1'b1;
        lfsr     = 16'd53977;
        last_rd  = '0;
        n_done   = 0;
        cycles   = 0;
        limit    = 0;
        err_byte = 0;
        err_line = 0;
        err_lat  = 0;
        for (int i = 0; i < 32; i++)
            vec_mem[i] = '1;                            // end marker
        for (int n = 0; n < 256; n++)
            slv_mem[n] = 8'(n) ^ 8'hA5;
        $readmemh("tests/i2c_vectors.hex", vec_mem);
        nvec = 0;
        while ((nvec < 32) && (vec_mem[nvec] != '1))
            nvec++;
        limit = nvec * (205 + 16) + 100;
        repeat (5) @(negedge dri_clk);
        rst_n = 1'b1;
        @(negedge dri_clk);
        idle_line = '{scl: 1'b1, sda_o: 1'b1, sda_oe: 1'b1};
        check_line(i2c_bus_pkg::i2c_line_t'({scl, sda_o, sda_oe}), idle_line);
        check_latency(int'(i2c_done), 0, "done after reset");
        for (int i = 0; i < nvec; i++)
            run_vector(vec_mem[i]);
        @(negedge dri_clk);                             // last done pulse counted
        check_latency(n_done, nvec, "done pulses");
        $display("errors: byte %0d, line %0d, latency %0d, vectors %0d",
                 err_byte, err_line, err_lat, nvec);
        if (err_byte + err_line + err_lat == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // hang guard
    initial begin
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge dri_clk);
            cycles++;
        end
        $display("hang: transactions did not finish within %0d cycles", limit);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* project.f */
+incdir+hw
hw/i2c_bus_pkg.sv
hw/i2c_txn_pkg.sv
hw/i2c_bit_engine.sv
hw/i2c_txn_seq.sv
hw/i2c_master.sv
tests/i2c_master_chk.sv
tests/tb_i2c_master.sv

/* Makefile */
# Verilator build and run of the I2C master testbench

OBJ = obj_dir
LOG = run.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f project.f \
		--top-module tb_i2c_master -Mdir $(OBJ) -o sim

run: build
	./$(OBJ)/sim | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f project.f --top-module tb_i2c_master

clean:
	rm -rf $(OBJ) $(LOG)

/* tests/i2c_vectors.hex */
// one transaction per line: rh_wl _ bit_ctrl _ addr _ data_w _ expected read byte
// slave memory starts as n xor a5, writes change it
0_0_0010_3c_00
1_0_0010_00_3c
1_0_0012_00_b7
0_1_1234_5a_00
1_1_1234_00_5a
1_1_0100_00_a5
0_0_00ff_00_00
1_0_00ff_00_00
1_0_007f_00_da
0_1_abcd_ff_00
1_0_00cd_00_ff
0_0_0080_81_00
0_0_0080_7e_00
1_1_5580_00_7e
1_0_0001_00_a4
0_1_0001_c3_00
1_0_0001_00_c3
